//--- cluster_boot_top.f
verilog/cluster_boot_pkg.sv
verilog/boot_controller.sv
verilog/core_ctrl_regs.sv
verilog/slot_addr_table.sv
verilog/rx_desc_fifo.sv
verilog/cluster_boot_top.sv
tb/cluster_boot_assert.sv
tb/cluster_boot_tb.sv

//--- Bender.yml
package:
  name: cluster_boot

sources:
  - verilog/cluster_boot_pkg.sv
  - verilog/boot_controller.sv
  - verilog/core_ctrl_regs.sv
  - verilog/slot_addr_table.sv
  - verilog/rx_desc_fifo.sv
  - verilog/cluster_boot_top.sv
  - target: test
    files:
      - tb/cluster_boot_assert.sv
      - tb/cluster_boot_tb.sv

//--- tb/cluster_boot_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cluster_boot_tb;

  import cluster_boot_pkg::*;

  // Start delay, 128 descriptors at half rate, and a wide margin
  localparam int timeout_cycles = 4000;

  logic       clk;
  logic       rst;
  core_mask_t core_run;
  slot_no_t   slot_rd_no;
  slot_addr_t slot_rd_addr;
  rx_desc_t   desc;
  logic       desc_valid;
  logic       desc_ready;
  logic       tx_enable;
  logic       rx_enable;
  integer     seed;
  int         cycle;
  int         rx_on;

  cluster_boot_top dut (
    .clk          (clk),
    .rst          (rst),
    .core_run     (core_run),
    .slot_rd_no   (slot_rd_no),
    .slot_rd_addr (slot_rd_addr),
    .desc         (desc),
    .desc_valid   (desc_valid),
    .desc_ready   (desc_ready),
    .tx_enable    (tx_enable),
    .rx_enable    (rx_enable)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    seed       = 32'h1074;
    rst        = 1'b1;
    desc_ready = 1'b0;
    slot_rd_no = '0;
    cycle      = 0;
    rx_on      = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // Run until rx_enable has held for 10 cycles, a checker fires or time runs out
    while (rx_on < 10 && cycle < timeout_cycles && dut.u_assert.fail_cnt == 0) begin
      @(posedge clk);
      cycle++;
      desc_ready <= 1'($random(seed)); // Consumer takes about every other cycle
      if (cycle >= 20)
        slot_rd_no <= slot_rd_no + 1'b1;
      if (rx_enable)
        rx_on++;
    end
    if (dut.u_assert.fail_cnt != 0 || rx_on < 10) begin
      $display("Test FAILED");
      if (dut.u_assert.fail_cnt != 0)
        $fatal(1, "A checker assertion failed at %0t", $time);
      else
        $fatal(1, "Timeout after %0d cycles, rx_enable was never held high", cycle);
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tb/cluster_boot_assert.sv
`timescale 1ns/100ps
`default_nettype none

module cluster_boot_assert (
  input logic                         clk,
  input logic                         rst,
  input cluster_boot_pkg::core_mask_t core_run,
  input cluster_boot_pkg::slot_no_t   slot_rd_no,
  input cluster_boot_pkg::slot_addr_t slot_rd_addr,
  input cluster_boot_pkg::rx_desc_t   desc,
  input logic                         desc_valid,
  input logic                         desc_ready,
  input logic                         tx_enable,
  input logic                         rx_enable
);

  import cluster_boot_pkg::*;

  int         fail_cnt = 0;
  int         cyc;
  logic [7:0] accepted; // Descriptors taken by the consumer so far
  rx_desc_t   exp_desc;

  // The walk steps the core number fastest
  assign exp_desc.core_no = core_no_t'(accepted % num_cores);
  assign exp_desc.slot_no = slot_no_t'(accepted / num_cores);

  always_ff @(posedge clk) begin
    if (rst) begin
      cyc      <= 0;
      accepted <= '0;
    end else begin
      cyc <= cyc + 1;
      if (desc_valid && desc_ready)
        accepted <= accepted + 1'b1;
    end
  end

  assert property (@(posedge clk) $fell(rst) |->
                   core_run == '0 && !desc_valid && !tx_enable && !rx_enable) else begin
    $error("ERROR %0t: outputs not idle after reset", $time);
    fail_cnt++;
  end

  assert property (@(posedge clk) disable iff (rst) cyc < boot_delay |-> core_run == '0) else begin
    $error("ERROR %0t: core released before the start delay ended", $time);
    fail_cnt++;
  end

  // A new bit may only join at the bottom, above the bits already set
  assert property (@(posedge clk) disable iff (rst) core_run != $past(core_run) |->
                   core_run == core_mask_t'({$past(core_run), 1'b1})) else begin
    $error("ERROR %0t: core_run changed out of order, now %b", $time, core_run);
    fail_cnt++;
  end

  assert property (@(posedge clk) disable iff (rst) $rose(tx_enable) |-> &core_run) else begin
    $error("ERROR %0t: tx_enable rose with core_run %b", $time, core_run);
    fail_cnt++;
  end

  assert property (@(posedge clk) disable iff (rst) cyc >= 20 |->
                   slot_rd_addr == slot_addr_t'(first_slot_addr + slot_rd_no * slot_addr_step))
  else begin
    $error("ERROR %0t: slot %0d reads base %h", $time, slot_rd_no, slot_rd_addr);
    fail_cnt++;
  end

  assert property (@(posedge clk) disable iff (rst) desc_valid && desc_ready |->
                   desc == exp_desc) else begin
    $error("ERROR %0t: descriptor %0d is %h, expected %h", $time, accepted, desc, exp_desc);
    fail_cnt++;
  end

  assert property (@(posedge clk) disable iff (rst) desc_valid && !desc_ready |=>
                   desc_valid && $stable(desc)) else begin
    $error("ERROR %0t: descriptor changed while stalled", $time);
    fail_cnt++;
  end

  assert property (@(posedge clk) disable iff (rst) rx_enable |->
                   tx_enable && accepted == 8'd128) else begin
    $error("ERROR %0t: rx_enable high with tx_enable %b and %0d descriptors taken",
           $time, tx_enable, accepted);
    fail_cnt++;
  end

  assert property (@(posedge clk) disable iff (rst) tx_enable |=> tx_enable) else begin
    $error("ERROR %0t: tx_enable dropped", $time);
    fail_cnt++;
  end

  assert property (@(posedge clk) disable iff (rst) rx_enable |=> rx_enable) else begin
    $error("ERROR %0t: rx_enable dropped", $time);
    fail_cnt++;
  end

endmodule

bind cluster_boot_top cluster_boot_assert u_assert (.*);

`default_nettype wire

//--- verilog/cluster_boot_top.sv
`timescale 1ns/100ps
`default_nettype none

module cluster_boot_top (
  input  logic                         clk,
  input  logic                         rst,

  output cluster_boot_pkg::core_mask_t core_run,

  input  cluster_boot_pkg::slot_no_t   slot_rd_no,
  output cluster_boot_pkg::slot_addr_t slot_rd_addr,

  output cluster_boot_pkg::rx_desc_t   desc,
  output logic                         desc_valid,
  input  logic                         desc_ready,

  output logic                         tx_enable,
  output logic                         rx_enable
);

  import cluster_boot_pkg::*;

  bus_aw_t    aw;
  logic       aw_valid;
  logic       aw_ready;
  bus_w_t     w;
  logic       w_valid;
  logic       w_ready;
  logic       b_valid;
  slot_no_t   slot_wr_no;
  slot_addr_t slot_wr_addr;
  logic       slot_wr_valid;
  rx_desc_t   desc_in;
  logic       desc_in_valid;
  logic       desc_in_ready;
  logic       fifo_empty;

  boot_controller u_boot_controller (
    .clk           (clk),
    .rst           (rst),
    .aw            (aw),
    .aw_valid      (aw_valid),
    .aw_ready      (aw_ready),
    .w             (w),
    .w_valid       (w_valid),
    .w_ready       (w_ready),
    .b_valid       (b_valid),
    .slot_wr_no    (slot_wr_no),
    .slot_wr_addr  (slot_wr_addr),
    .slot_wr_valid (slot_wr_valid),
    .desc_in       (desc_in),
    .desc_in_valid (desc_in_valid),
    .desc_in_ready (desc_in_ready),
    .fifo_empty    (fifo_empty),
    .tx_enable     (tx_enable),
    .rx_enable     (rx_enable)
  );

  core_ctrl_regs u_core_ctrl_regs (
    .clk      (clk),
    .rst      (rst),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .core_run (core_run)
  );

  slot_addr_table u_slot_addr_table (
    .clk      (clk),
    .rst      (rst),
    .wr_no    (slot_wr_no),
    .wr_addr  (slot_wr_addr),
    .wr_valid (slot_wr_valid),
    .rd_no    (slot_rd_no),
    .rd_addr  (slot_rd_addr)
  );

  rx_desc_fifo u_rx_desc_fifo (
    .clk       (clk),
    .rst       (rst),
    .in        (desc_in),
    .in_valid  (desc_in_valid),
    .in_ready  (desc_in_ready),
    .out       (desc),
    .out_valid (desc_valid),
    .out_ready (desc_ready),
    .empty     (fifo_empty)
  );

endmodule

`default_nettype wire

//--- verilog/rx_desc_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module rx_desc_fifo (
  input  logic                       clk,
  input  logic                       rst,

  input  cluster_boot_pkg::rx_desc_t in,
  input  logic                       in_valid,
  output logic                       in_ready,

  output cluster_boot_pkg::rx_desc_t out,
  output logic                       out_valid,
  input  logic                       out_ready,

  output logic                       empty
);

  import cluster_boot_pkg::*;

  rx_desc_t              mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic [fifo_ptr_w:0]   count;
  logic                  do_wr;
  logic                  do_rd;

  assign in_ready  = (count != (fifo_ptr_w + 1)'(fifo_depth));
  assign out_valid = (count != '0);
  assign empty     = (count == '0);
  assign do_wr     = in_valid && in_ready;
  assign do_rd     = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (do_wr)
      mem[wr_ptr] <= in;
  end

  assign out = mem[rd_ptr];

  // Pointers wrap naturally at the queue depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_wr && !do_rd)
        count <= count + 1'b1;
      else if (do_rd && !do_wr)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/slot_addr_table.sv
`timescale 1ns/100ps
`default_nettype none

module slot_addr_table (
  input  logic                         clk,
  input  logic                         rst,

  input  cluster_boot_pkg::slot_no_t   wr_no,
  input  cluster_boot_pkg::slot_addr_t wr_addr,
  input  logic                         wr_valid,

  input  cluster_boot_pkg::slot_no_t   rd_no,
  output cluster_boot_pkg::slot_addr_t rd_addr
);

  import cluster_boot_pkg::*;

  slot_addr_t table_q [num_slots];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_slots; i++)
        table_q[i] <= '0;
    end else if (wr_valid) begin
      table_q[wr_no] <= wr_addr;
    end
  end

  assign rd_addr = table_q[rd_no]; // Asynchronous lookup for the receive path

endmodule

`default_nettype wire

//--- verilog/core_ctrl_regs.sv
`timescale 1ns/100ps
`default_nettype none

module core_ctrl_regs (
  input  logic                         clk,
  input  logic                         rst,

  input  cluster_boot_pkg::bus_aw_t    aw,
  input  logic                         aw_valid,
  output logic                         aw_ready,
  input  cluster_boot_pkg::bus_w_t     w,
  input  logic                         w_valid,
  output logic                         w_ready,
  output logic                         b_valid,

  output cluster_boot_pkg::core_mask_t core_run
);

  import cluster_boot_pkg::*;

  bus_aw_t    aw_q;
  bus_w_t     w_q;
  logic       aw_held;
  logic       w_held;
  core_mask_t core_rst;
  core_no_t   core_idx;
  logic       reg_hit;

  assign aw_ready = !aw_held;
  assign w_ready  = !w_held;

  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready)
      aw_q <= aw;
    if (w_valid && w_ready)
      w_q <= w;
  end

  // The upper address bits pick the core window
  assign core_idx = aw_q.addr[bus_addr_w-1:reg_offset_w];
  assign reg_hit  = (aw_q.addr[reg_offset_w-1:0] == reset_reg_offset) &&
                    w_q.strb[reset_strb_byte] && w_q.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      b_valid  <= 1'b0;
      core_rst <= '1; // All cores start held in reset
    end else begin
      b_valid <= aw_held && w_held;
      if (aw_held && w_held) begin
        aw_held <= 1'b0;
        w_held  <= 1'b0;
      end else begin
        if (aw_valid && aw_ready)
          aw_held <= 1'b1;
        if (w_valid && w_ready)
          w_held <= 1'b1;
      end
      // Held beats are still intact during the response cycle
      if (b_valid && reg_hit)
        core_rst[core_idx] <= w_q.data[reset_bit_pos];
    end
  end

  assign core_run = ~core_rst;

endmodule

`default_nettype wire

//--- verilog/boot_controller.sv
`timescale 1ns/100ps
`default_nettype none

module boot_controller (
  input  logic                        clk,
  input  logic                        rst,

  output cluster_boot_pkg::bus_aw_t   aw,
  output logic                        aw_valid,
  input  logic                        aw_ready,
  output cluster_boot_pkg::bus_w_t    w,
  output logic                        w_valid,
  input  logic                        w_ready,
  input  logic                        b_valid,

  output cluster_boot_pkg::slot_no_t   slot_wr_no,
  output cluster_boot_pkg::slot_addr_t slot_wr_addr,
  output logic                         slot_wr_valid,

  output cluster_boot_pkg::rx_desc_t  desc_in,
  output logic                        desc_in_valid,
  input  logic                        desc_in_ready,
  input  logic                        fifo_empty,

  output logic                        tx_enable,
  output logic                        rx_enable
);

  import cluster_boot_pkg::*;

  boot_state_t             state;
  logic [delay_cnt_w-1:0]  delay_cnt;
  core_no_t                core_sel;
  logic                    slot_loaded;
  logic                    walk_done;

  // The release write clears the reset bit of the selected core
  assign aw.addr = {core_sel, reset_reg_offset};
  assign w.data  = '0;
  assign w.strb  = reset_reg_strb;
  assign w.last  = 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= wait_delay;
      delay_cnt <= '0;
      core_sel  <= '0;
      aw_valid  <= 1'b0;
      w_valid   <= 1'b0;
    end else begin
      case (state)
        wait_delay: begin
          if (delay_cnt == delay_cnt_w'(boot_delay - 1)) begin
            state    <= issue;
            aw_valid <= 1'b1;
            w_valid  <= 1'b1;
          end else begin
            delay_cnt <= delay_cnt + 1'b1;
          end
        end
        issue: begin
          // The two beats may be taken in different cycles
          if (aw_ready)
            aw_valid <= 1'b0;
          if (w_ready)
            w_valid <= 1'b0;
          if ((!aw_valid || aw_ready) && (!w_valid || w_ready))
            state <= wait_done;
        end
        wait_done: begin
          if (b_valid) begin
            if (core_sel == core_no_t'(num_cores - 1)) begin
              state <= done;
            end else begin
              core_sel <= core_sel + 1'b1;
              state    <= issue;
              aw_valid <= 1'b1;
              w_valid  <= 1'b1;
            end
          end
        end
        default: state <= done;
      endcase
    end
  end

  // Slot base addresses go out one per cycle starting with slot 0
  always_ff @(posedge clk) begin
    if (rst) begin
      slot_wr_valid <= 1'b0;
      slot_loaded   <= 1'b0;
      slot_wr_no    <= '0;
      slot_wr_addr  <= first_slot_addr;
    end else if (slot_wr_valid) begin
      slot_wr_no   <= slot_wr_no + 1'b1;
      slot_wr_addr <= slot_wr_addr + slot_addr_step;
      if (slot_wr_no == slot_no_t'(num_slots - 1)) begin
        slot_wr_valid <= 1'b0;
        slot_loaded   <= 1'b1;
      end
    end else if (!slot_loaded) begin
      slot_wr_valid <= 1'b1;
    end
  end

  // Descriptor walk with the core number stepping fastest
  always_ff @(posedge clk) begin
    if (rst) begin
      desc_in       <= '0;
      desc_in_valid <= 1'b0;
      walk_done     <= 1'b0;
    end else if (desc_in_valid) begin
      if (desc_in_ready) begin
        desc_in.core_no <= desc_in.core_no + 1'b1;
        if (&desc_in.core_no)
          desc_in.slot_no <= desc_in.slot_no + 1'b1;
        if ((&desc_in.core_no) && (&desc_in.slot_no)) begin
          desc_in_valid <= 1'b0;
          walk_done     <= 1'b1;
        end
      end
    end else if (!walk_done) begin
      desc_in_valid <= 1'b1;
    end
  end

  assign tx_enable = (state == done);

  always_ff @(posedge clk) begin
    if (rst)
      rx_enable <= 1'b0;
    else if (tx_enable && walk_done && fifo_empty)
      rx_enable <= 1'b1; // Sticky until the next reset
  end

endmodule

`default_nettype wire

//--- verilog/cluster_boot_pkg.sv
`default_nettype none

package cluster_boot_pkg;

  // Cluster dimensions
  localparam int num_cores   = 8;
  localparam int num_slots   = 16;
  localparam int core_no_w   = 3;
  localparam int slot_no_w   = 4;
  localparam int bus_addr_w  = 19;
  localparam int bus_data_w  = 64;
  localparam int bus_strb_w  = bus_data_w / 8;
  localparam int slot_addr_w = 7;

  // Receive slot layout in the shared memory
  localparam logic [slot_addr_w-1:0] first_slot_addr = 7'h40;
  localparam logic [slot_addr_w-1:0] slot_addr_step  = 7'h04;

  localparam int boot_delay  = 1000; // Cycles from reset to the first release write
  localparam int delay_cnt_w = $clog2(boot_delay + 1);

  // Each core owns a 64 KiB window with the reset register at its top
  localparam int                      reg_offset_w     = 16;
  localparam logic [reg_offset_w-1:0] reset_reg_offset = 16'hFFF8;
  localparam int                      reset_strb_byte  = 7;
  localparam int                      reset_bit_pos    = 56;
  localparam logic [bus_strb_w-1:0]   reset_reg_strb   = 8'h80;

  localparam int fifo_depth = 16;
  localparam int fifo_ptr_w = 4;

  typedef logic [core_no_w-1:0]   core_no_t;
  typedef logic [slot_no_w-1:0]   slot_no_t;
  typedef logic [slot_addr_w-1:0] slot_addr_t;
  typedef logic [bus_addr_w-1:0]  bus_addr_t;
  typedef logic [bus_data_w-1:0]  bus_data_t;
  typedef logic [num_cores-1:0]   core_mask_t;

  typedef struct packed {
    core_no_t core_no;
    slot_no_t slot_no;
  } rx_desc_t;

  typedef struct packed {
    bus_addr_t addr;
  } bus_aw_t;

  typedef struct packed {
    bus_data_t               data;
    logic [bus_strb_w-1:0]   strb;
    logic                    last;
  } bus_w_t;

  typedef enum logic [1:0] {
    wait_delay,
    issue,
    wait_done,
    done
  } boot_state_t;

endpackage

`default_nettype wire
